// File: Bender.yml
package:
  name: processorci_bus

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pci_bus_pkg.sv
      - logic/wb_ack_timer.sv
      - logic/axi_wb_bridge.sv
      - logic/processorci_bus_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_processorci_bus.sv

vendor_package: []

// File: logic/axi_wb_bridge.sv
`timescale 1ns/1ps
`include "pci_bus_settings.svh"

module axi_wb_bridge
    import pci_bus_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // Write address channel
    input  axi_aw_t aw_i,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,

    // Write data channel
    input  axi_w_t  w_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,

    // Write response channel
    output axi_b_t  b_o,
    output logic    b_valid_o,
    input  logic    b_ready_i,

    // Read address channel
    input  axi_ar_t ar_i,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,

    // Read data channel
    output axi_r_t  r_o,
    output logic    r_valid_o,
    input  logic    r_ready_i,

    // Wishbone master
    output wb_req_t wb_req_o,
    input  wb_rsp_t wb_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUS  = 2'd1,
        ST_RESP = 2'd2
    } state_e;

    state_e                 state_q;
    logic                   prio_wr_q;  // Write side wins the next tie
    logic                   cyc_q;
    logic                   is_wr_q;

    logic [`PCI_ID_W-1:0]   id_q;
    logic [`PCI_ADDR_W-1:0] addr_q;
    logic [`PCI_DATA_W-1:0] wdata_q;
    logic [`PCI_SEL_W-1:0]  sel_q;
    logic [`PCI_DATA_W-1:0] rdata_q;
    axi_resp_t              resp_q;

    logic wr_req;
    logic rd_req;
    logic wr_go;
    logic rd_go;
    logic timeout;
    logic bus_done;
    logic rsp_taken;

    assign wr_req = aw_valid_i && w_valid_i;    // Both halves of a write present
    assign rd_req = ar_valid_i;

    // Arbitration, only in idle
    assign wr_go = (state_q == ST_IDLE) && wr_req && (prio_wr_q || !rd_req);
    assign rd_go = (state_q == ST_IDLE) && rd_req && (!prio_wr_q || !wr_req);

    assign bus_done  = cyc_q && (wb_rsp_i.ack || timeout);
    assign rsp_taken = is_wr_q ? b_ready_i : r_ready_i;

    wb_ack_timer u_ack_timer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .busy_i    (cyc_q),
        .ack_i     (wb_rsp_i.ack),
        .expired_o (timeout)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            prio_wr_q <= 1'b1;
            cyc_q     <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_go || rd_go) begin
                        state_q   <= ST_BUS;
                        cyc_q     <= 1'b1;
                        prio_wr_q <= rd_go;  // Other side gets the next tie
                    end
                end
                ST_BUS: begin
                    if (bus_done) begin
                        state_q <= ST_RESP;
                        cyc_q   <= 1'b0;
                    end
                end
                ST_RESP: begin
                    if (rsp_taken) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Transaction payload
    always_ff @(posedge clk_i) begin
        if (wr_go) begin
            is_wr_q <= 1'b1;
            id_q    <= aw_i.id;
            addr_q  <= aw_i.addr;
            wdata_q <= w_i.data;
            sel_q   <= w_i.strb;    // Strobe becomes the select
        end else if (rd_go) begin
            is_wr_q <= 1'b0;
            id_q    <= ar_i.id;
            addr_q  <= ar_i.addr;
            wdata_q <= '0;
            sel_q   <= '1;          // Reads fetch the whole word
        end

        // Response captured on ack or abandon
        if (bus_done) begin
            rdata_q <= wb_rsp_i.ack ? wb_rsp_i.rdata : '0;
            resp_q  <= wb_rsp_i.ack ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign aw_ready_o = wr_go;
    assign w_ready_o  = wr_go;
    assign ar_ready_o = rd_go;

    always_comb begin
        wb_req_o.cyc   = cyc_q;
        wb_req_o.stb   = cyc_q;
        wb_req_o.we    = is_wr_q;
        wb_req_o.sel   = sel_q;
        wb_req_o.addr  = addr_q;
        wb_req_o.wdata = wdata_q;
    end

    assign b_valid_o = (state_q == ST_RESP) && is_wr_q;
    assign r_valid_o = (state_q == ST_RESP) && !is_wr_q;

    always_comb begin
        b_o.id   = id_q;
        b_o.resp = resp_q;
        r_o.id   = id_q;
        r_o.data = rdata_q;
        r_o.resp = resp_q;
        r_o.last = 1'b1;
    end

    // Slave sees a frozen request until it answers or the timer gives up
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_req_o.stb && !wb_rsp_i.ack && !timeout |=> $stable(wb_req_o)
    );

    // Responses held unchanged under back-pressure
    a_b_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o)
    );

    a_r_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o)
    );

    // Nothing accepted while a bus cycle or a response is pending
    a_ready_idle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (aw_ready_o || w_ready_o || ar_ready_o) |-> !wb_req_o.cyc && !b_valid_o && !r_valid_o
    );

endmodule

// File: logic/pci_bus_pkg.sv
`include "pci_bus_settings.svh"

package pci_bus_pkg;

    // AXI response encoding, only two codes used here
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    // Write address channel
    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_ADDR_W-1:0] addr;
    } axi_aw_t;

    // Write data channel, single beat so no last flag
    typedef struct packed {
        logic [`PCI_DATA_W-1:0] data;
        logic [`PCI_SEL_W-1:0]  strb;   // Byte enables
    } axi_w_t;

    // Write response channel
    typedef struct packed {
        logic [`PCI_ID_W-1:0] id;
        axi_resp_t            resp;
    } axi_b_t;

    // Read address channel
    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_ADDR_W-1:0] addr;
    } axi_ar_t;

    // Read data channel
    typedef struct packed {
        logic [`PCI_ID_W-1:0]   id;
        logic [`PCI_DATA_W-1:0] data;
        axi_resp_t              resp;
        logic                   last;   // Always set, no bursts
    } axi_r_t;

    // Wishbone master side, driven by the bridge
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;     // 1 = write
        logic [`PCI_SEL_W-1:0]  sel;
        logic [`PCI_ADDR_W-1:0] addr;
        logic [`PCI_DATA_W-1:0] wdata;
    } wb_req_t;

    // Wishbone slave side, driven by the memory
    typedef struct packed {
        logic                   ack;
        logic [`PCI_DATA_W-1:0] rdata;
    } wb_rsp_t;

endpackage

// File: logic/pci_bus_settings.svh
`ifndef PCI_BUS_SETTINGS_SVH
`define PCI_BUS_SETTINGS_SVH

// Bus widths shared by the instruction and data ports
`define PCI_ADDR_W 32
`define PCI_DATA_W 32
`define PCI_ID_W   4

// One select bit per data byte
`define PCI_SEL_W (`PCI_DATA_W / 8)

// Cycles an open Wishbone cycle may wait for ack before it is dropped
`define PCI_WB_TIMEOUT 16

`endif

// File: logic/processorci_bus_top.sv
`timescale 1ns/1ps

module processorci_bus_top
    import pci_bus_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // Instruction port from the core
    input  axi_aw_t axi_i_aw_i,
    input  logic    axi_i_aw_valid_i,
    output logic    axi_i_aw_ready_o,
    input  axi_w_t  axi_i_w_i,
    input  logic    axi_i_w_valid_i,
    output logic    axi_i_w_ready_o,
    output axi_b_t  axi_i_b_o,
    output logic    axi_i_b_valid_o,
    input  logic    axi_i_b_ready_i,
    input  axi_ar_t axi_i_ar_i,
    input  logic    axi_i_ar_valid_i,
    output logic    axi_i_ar_ready_o,
    output axi_r_t  axi_i_r_o,
    output logic    axi_i_r_valid_o,
    input  logic    axi_i_r_ready_i,

    // Data port from the core
    input  axi_aw_t axi_d_aw_i,
    input  logic    axi_d_aw_valid_i,
    output logic    axi_d_aw_ready_o,
    input  axi_w_t  axi_d_w_i,
    input  logic    axi_d_w_valid_i,
    output logic    axi_d_w_ready_o,
    output axi_b_t  axi_d_b_o,
    output logic    axi_d_b_valid_o,
    input  logic    axi_d_b_ready_i,
    input  axi_ar_t axi_d_ar_i,
    input  logic    axi_d_ar_valid_i,
    output logic    axi_d_ar_ready_o,
    output axi_r_t  axi_d_r_o,
    output logic    axi_d_r_valid_o,
    input  logic    axi_d_r_ready_i,

    // Wishbone memory ports
    output wb_req_t core_wb_req_o,      // Instruction memory
    input  wb_rsp_t core_wb_rsp_i,
    output wb_req_t data_mem_wb_req_o,  // Data memory
    input  wb_rsp_t data_mem_wb_rsp_i
);

    axi_wb_bridge u_instr_bridge (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .aw_i       (axi_i_aw_i),
        .aw_valid_i (axi_i_aw_valid_i),
        .aw_ready_o (axi_i_aw_ready_o),
        .w_i        (axi_i_w_i),
        .w_valid_i  (axi_i_w_valid_i),
        .w_ready_o  (axi_i_w_ready_o),
        .b_o        (axi_i_b_o),
        .b_valid_o  (axi_i_b_valid_o),
        .b_ready_i  (axi_i_b_ready_i),
        .ar_i       (axi_i_ar_i),
        .ar_valid_i (axi_i_ar_valid_i),
        .ar_ready_o (axi_i_ar_ready_o),
        .r_o        (axi_i_r_o),
        .r_valid_o  (axi_i_r_valid_o),
        .r_ready_i  (axi_i_r_ready_i),
        .wb_req_o   (core_wb_req_o),
        .wb_rsp_i   (core_wb_rsp_i)
    );

    axi_wb_bridge u_data_bridge (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .aw_i       (axi_d_aw_i),
        .aw_valid_i (axi_d_aw_valid_i),
        .aw_ready_o (axi_d_aw_ready_o),
        .w_i        (axi_d_w_i),
        .w_valid_i  (axi_d_w_valid_i),
        .w_ready_o  (axi_d_w_ready_o),
        .b_o        (axi_d_b_o),
        .b_valid_o  (axi_d_b_valid_o),
        .b_ready_i  (axi_d_b_ready_i),
        .ar_i       (axi_d_ar_i),
        .ar_valid_i (axi_d_ar_valid_i),
        .ar_ready_o (axi_d_ar_ready_o),
        .r_o        (axi_d_r_o),
        .r_valid_o  (axi_d_r_valid_o),
        .r_ready_i  (axi_d_r_ready_i),
        .wb_req_o   (data_mem_wb_req_o),
        .wb_rsp_i   (data_mem_wb_rsp_i)
    );

endmodule

// File: logic/wb_ack_timer.sv
`timescale 1ns/1ps
`include "pci_bus_settings.svh"

module wb_ack_timer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic busy_i,    // Wishbone cycle open
    input  logic ack_i,     // Slave answer
    output logic expired_o  // One-cycle pulse on timeout
);

    localparam int unsigned LIMIT = `PCI_WB_TIMEOUT;
    localparam int unsigned CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] cnt_q;

    // Counter saturates at LIMIT so the pulse cannot repeat
    always_ff @(posedge clk_i) begin
        if (rst_i || !busy_i) begin
            cnt_q <= '0;
        end else if (!ack_i && cnt_q != CNT_W'(LIMIT)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // First stb cycle counts as zero, so busy lasts LIMIT cycles
    assign expired_o = busy_i && !ack_i && (cnt_q == CNT_W'(LIMIT - 1));

    // Expiry lands on the LIMIT-th silent cycle of an open cycle
    a_expire_at_limit: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ($rose(busy_i) && !ack_i) ##1 (busy_i && !ack_i) [* (LIMIT - 1)] |-> expired_o
    );

endmodule

// File: processorci_bus.f
+incdir+logic
logic/pci_bus_pkg.sv
logic/wb_ack_timer.sv
logic/axi_wb_bridge.sv
logic/processorci_bus_top.sv
test/tb_processorci_bus.sv

// File: test/bus_golden.mem
// port op id addr wdata strb ackdelay resp rdata   (op 0 write, 1 read, 2 write+read of addr+4)
// ackdelay above 10 hex never acknowledges; rdata is the expected read word
0 0 1 00000010 11223344 f 01 0 00000000
0 1 2 00000010 00000000 0 02 0 11223344
0 0 3 00000014 aabbccdd f 00 0 00000000
0 0 4 00000014 00005566 3 01 0 00000000
0 1 5 00000014 00000000 0 01 0 aabb5566
0 1 6 00000020 00000000 0 20 2 00000000
0 0 7 00000024 cafef00d f 20 2 00000000
0 0 a 00000034 13579bdf f 03 0 00000000
0 2 9 00000030 0badf00d f 01 0 13579bdf
0 1 b 00000030 00000000 0 00 0 0badf00d
1 0 1 00000100 deadbeef f 00 0 00000000
1 0 2 00000100 12003400 a 02 0 00000000
1 1 3 00000100 00000000 0 05 0 12ad34ef
1 0 4 00000104 01020304 f 02 0 00000000
1 2 5 00000100 a5a5a5a5 f 00 0 01020304
1 1 6 00000100 00000000 0 01 0 a5a5a5a5
1 0 7 00000200 ffffffff f 11 2 00000000
1 1 8 00000104 00000000 0 0f 0 01020304

// File: test/tb_processorci_bus.sv
`timescale 1ns/1ps
`include "pci_bus_settings.svh"

module tb_processorci_bus
    import pci_bus_pkg::*;
();

    localparam int N_ENTRIES = 18;
    localparam int N_FIELDS  = 9;
    localparam int MAX_CYCLES = N_ENTRIES * (`PCI_WB_TIMEOUT + 12) + 10;

    logic clk;
    logic rst;

    // Index 0 is the instruction port, 1 the data port
    axi_aw_t aw [2];
    logic    aw_valid [2];
    logic    aw_ready [2];
    axi_w_t  w [2];
    logic    w_valid [2];
    logic    w_ready [2];
    axi_b_t  b [2];
    logic    b_valid [2];
    logic    b_ready [2];
    axi_ar_t ar [2];
    logic    ar_valid [2];
    logic    ar_ready [2];
    axi_r_t  r [2];
    logic    r_valid [2];
    logic    r_ready [2];
    wb_req_t req [2];
    wb_rsp_t rsp [2];

    logic [31:0] gold [0:N_ENTRIES*N_FIELDS-1];
    logic [31:0] mem [2][256];
    int          ack_delay [2];
    int          errors;
    int          cycles;

    processorci_bus_top u_dut (
        .clk_i             (clk),
        .rst_i             (rst),
        .axi_i_aw_i        (aw[0]),
        .axi_i_aw_valid_i  (aw_valid[0]),
        .axi_i_aw_ready_o  (aw_ready[0]),
        .axi_i_w_i         (w[0]),
        .axi_i_w_valid_i   (w_valid[0]),
        .axi_i_w_ready_o   (w_ready[0]),
        .axi_i_b_o         (b[0]),
        .axi_i_b_valid_o   (b_valid[0]),
        .axi_i_b_ready_i   (b_ready[0]),
        .axi_i_ar_i        (ar[0]),
        .axi_i_ar_valid_i  (ar_valid[0]),
        .axi_i_ar_ready_o  (ar_ready[0]),
        .axi_i_r_o         (r[0]),
        .axi_i_r_valid_o   (r_valid[0]),
        .axi_i_r_ready_i   (r_ready[0]),
        .axi_d_aw_i        (aw[1]),
        .axi_d_aw_valid_i  (aw_valid[1]),
        .axi_d_aw_ready_o  (aw_ready[1]),
        .axi_d_w_i         (w[1]),
        .axi_d_w_valid_i   (w_valid[1]),
        .axi_d_w_ready_o   (w_ready[1]),
        .axi_d_b_o         (b[1]),
        .axi_d_b_valid_o   (b_valid[1]),
        .axi_d_b_ready_i   (b_ready[1]),
        .axi_d_ar_i        (ar[1]),
        .axi_d_ar_valid_i  (ar_valid[1]),
        .axi_d_ar_ready_o  (ar_ready[1]),
        .axi_d_r_o         (r[1]),
        .axi_d_r_valid_o   (r_valid[1]),
        .axi_d_r_ready_i   (r_ready[1]),
        .core_wb_req_o     (req[0]),
        .core_wb_rsp_i     (rsp[0]),
        .data_mem_wb_req_o (req[1]),
        .data_mem_wb_rsp_i (rsp[1])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_b(input axi_b_t got, input axi_b_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s B id=%h resp=%h, expected id=%h resp=%h",
                     $time, what, got.id, got.resp, exp.id, exp.resp);
        end
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s R id=%h data=%h resp=%h last=%b, expected %h %h %h %b",
                     $time, what, got.id, got.data, got.resp, got.last,
                     exp.id, exp.data, exp.resp, exp.last);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    // Wishbone slave with a programmable ack delay
    task automatic serve_memory(input int p);
        int wait_cnt;
        int idx;
        wait_cnt = 0;
        forever begin
            @(negedge clk);
            rsp[p].ack   = 1'b0;
            rsp[p].rdata = '0;
            if (!rst && req[p].cyc && req[p].stb) begin
                if (wait_cnt == ack_delay[p]) begin
                    idx = req[p].addr[9:2];
                    if (req[p].we) begin
                        for (int i = 0; i < 4; i++) begin
                            if (req[p].sel[i]) mem[p][idx][8*i +: 8] = req[p].wdata[8*i +: 8];
                        end
                    end else begin
                        rsp[p].rdata = mem[p][idx];
                    end
                    rsp[p].ack = 1'b1;
                    wait_cnt   = 0;
                end else begin
                    wait_cnt++;
                end
            end else begin
                wait_cnt = 0;
            end
        end
    endtask

    task automatic do_write(input int p, input logic [3:0] id, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input axi_resp_t exp_resp);
        axi_b_t exp_b;
        axi_b_t first_b;
        int     stall;
        exp_b.id   = id;
        exp_b.resp = exp_resp;
        @(negedge clk);
        aw[p].id     = id;
        aw[p].addr   = addr;
        w[p].data    = data;
        w[p].strb    = strb;
        aw_valid[p]  = 1'b1;
        w_valid[p]   = 1'b1;
        do @(posedge clk); while (!(aw_ready[p] && w_ready[p]));
        @(negedge clk);
        aw_valid[p] = 1'b0;
        w_valid[p]  = 1'b0;
        do @(posedge clk); while (!b_valid[p]);
        if (req[p].cyc) report_failure("Wishbone cycle still open while write response is valid");
        first_b = b[p];
        check_b(first_b, exp_b, "write");
        stall = $urandom % 4;
        repeat (stall) begin
            @(posedge clk);
            if (!b_valid[p]) report_failure("Write response valid dropped before ready");
            check_b(b[p], first_b, "held write");
            if (aw_ready[p] || w_ready[p] || ar_ready[p]) begin
                report_failure("Bridge accepted a request while a write response was pending");
            end
        end
        @(negedge clk);
        b_ready[p] = 1'b1;
        @(posedge clk);
        check_b(b[p], first_b, "accepted write");
        @(negedge clk);
        b_ready[p] = 1'b0;
    endtask

    task automatic do_read(input int p, input logic [3:0] id, input logic [31:0] addr,
                           input axi_resp_t exp_resp, input logic [31:0] exp_data);
        axi_r_t exp_r;
        axi_r_t first_r;
        int     stall;
        exp_r.id   = id;
        exp_r.data = exp_data;
        exp_r.resp = exp_resp;
        exp_r.last = 1'b1;
        @(negedge clk);
        ar[p].id     = id;
        ar[p].addr   = addr;
        ar_valid[p]  = 1'b1;
        do @(posedge clk); while (!ar_ready[p]);
        @(negedge clk);
        ar_valid[p] = 1'b0;
        do @(posedge clk); while (!r_valid[p]);
        if (req[p].cyc) report_failure("Wishbone cycle still open while read response is valid");
        first_r = r[p];
        check_r(first_r, exp_r, "read");
        stall = $urandom % 4;
        repeat (stall) begin
            @(posedge clk);
            if (!r_valid[p]) report_failure("Read response valid dropped before ready");
            check_r(r[p], first_r, "held read");
            if (aw_ready[p] || w_ready[p] || ar_ready[p]) begin
                report_failure("Bridge accepted a request while a read response was pending");
            end
        end
        @(negedge clk);
        r_ready[p] = 1'b1;
        @(posedge clk);
        check_r(r[p], first_r, "accepted read");
        @(negedge clk);
        r_ready[p] = 1'b0;
    endtask

    // Walks the golden entries that belong to one port
    task automatic run_port(input int p);
        int          base;
        logic [31:0] addr;
        for (int e = 0; e < N_ENTRIES; e++) begin
            base = e * N_FIELDS;
            if (gold[base] == p) begin
                addr         = gold[base+3];
                ack_delay[p] = gold[base+6];
                case (gold[base+1])
                    0: do_write(p, gold[base+2], addr, gold[base+4], gold[base+5], gold[base+7]);
                    1: do_read(p, gold[base+2], addr, gold[base+7], gold[base+8]);
                    default: begin
                        // Write and read of the next word presented together
                        fork
                            do_write(p, gold[base+2], addr, gold[base+4], gold[base+5],
                                     gold[base+7]);
                            do_read(p, gold[base+2], addr + 32'd4, gold[base+7], gold[base+8]);
                        join
                    end
                endcase
            end
        end
    endtask

    initial begin
        errors = 0;
        cycles = 0;
        rst    = 1'b1;
        void'($urandom(32'hb630));
        for (int p = 0; p < 2; p++) begin
            aw[p]        = '0;
            aw_valid[p]  = 1'b0;
            w[p]         = '0;
            w_valid[p]   = 1'b0;
            b_ready[p]   = 1'b0;
            ar[p]        = '0;
            ar_valid[p]  = 1'b0;
            r_ready[p]   = 1'b0;
            rsp[p]       = '0;
            ack_delay[p] = 0;
            for (int i = 0; i < 256; i++) begin
                mem[p][i] = 32'h5a5a_0000 ^ (i << 2) ^ (p << 24);   // Unique per address
            end
        end
        $readmemh("test/bus_golden.mem", gold);
        fork
            serve_memory(0);
            serve_memory(1);
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (2) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
